// File: pio.f
design/pio_host_pkg.sv
design/pio_isa_pkg.sv
design/pio_fifo.sv
design/pio_clock_div.sv
design/pio_machine.sv
design/pio.sv
test/pio_sva.sv
test/pio_tb.sv

// File: Bender.yml
package:
  name: pio

sources:
  # Packages first, then leaf modules, then the top level
  - files:
      - design/pio_host_pkg.sv
      - design/pio_isa_pkg.sv
      - design/pio_fifo.sv
      - design/pio_clock_div.sv
      - design/pio_machine.sv
      - design/pio.sv

  - target: test
    files:
      - test/pio_sva.sv
      - test/pio_tb.sv

// File: test/pio_tb.sv
`timescale 1ns/10ps

module pio_tb import pio_host_pkg::*, pio_isa_pkg::*; ();

  logic        clk;
  logic        reset;
  logic [1:0]  mindex;
  logic [31:0] din;
  logic [4:0]  index;
  logic [3:0]  action;
  logic [31:0] dout;
  logic [31:0] gpio_in;
  logic [31:0] gpio_out;
  logic [31:0] gpio_dir;
  logic        irq0;
  logic        irq1;
  logic [3:0]  full;
  logic [3:0]  empty;
  logic [31:0] lfsr_state = 32'ha9a3_4bf9;

  pio dut_i (
    .clk      (clk),
    .reset    (reset),
    .mindex   (mindex),
    .din      (din),
    .index    (index),
    .action   (action),
    .dout     (dout),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir),
    .irq0     (irq0),
    .irq1     (irq1),
    .full     (full),
    .empty    (empty)
  );

  bind pio pio_sva sva_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic abort_run(input string msg);
    $display("%s at %0t ns", msg, $time);
    stop_run();
  endtask

  always @(negedge clk) begin
    if (dut_i.sva_i.error_count != 0) begin
      abort_run("a bound assertion in pio_sva failed");
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    for (int b = 0; b < 32; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [15:0] instr_word(input logic [2:0] op, input logic [2:0] code,
                                             input logic [4:0] data);
    return {op, 5'd0, code, data};                      // No delay
  endfunction

  function automatic logic [15:0] pushpull_word(input logic pull, input logic block);
    return (16'(op_pushpull) << op_lsb) | (16'(pull) << pull_bit) | (16'(block) << block_bit);
  endfunction

  function automatic logic [31:0] pend_word(input int start, input int last, input int wrap);
    return (32'(start) << pstart_lsb) | (32'(last) << pend_lsb) | (32'(wrap) << wrap_lsb);
  endfunction

  function automatic logic [31:0] grps_word(input int base, input int count);
    return (32'(base) << grp_set_base_lsb) | (32'(count) << grp_set_count_lsb);
  endfunction

  // Low count bits of value moved up to pin base
  function automatic logic [31:0] place(input int base, input int count,
                                        input logic [31:0] value);
    return (value & ((32'd1 << count) - 32'd1)) << base;
  endfunction

  // Called on a falling edge and returns on the next one
  task automatic host_action(input logic [3:0] a, input logic [1:0] m, input logic [4:0] idx,
                             input logic [31:0] d);
    action = a;
    mindex = m;
    index  = idx;
    din    = d;
    @(negedge clk);
    action = act_none;
  endtask

  task automatic load_instr(input logic [4:0] addr, input logic [15:0] word);
    host_action(act_instr, 2'd0, addr, 32'(word));
  endtask

  task automatic pull_word(input logic [1:0] m, output logic [31:0] w);
    int n;
    n = 0;
    while (empty[m]) begin
      @(negedge clk);
      n++;
      if (n > 200) abort_run($sformatf("timeout waiting for receive FIFO %0d", m));
    end
    host_action(act_pull, m, 5'd0, 32'd0);
    w = dout;                                           // Updated on the edge just passed
  endtask

  task automatic wait_dirs(input logic [31:0] expected, input string what);
    int n;
    n = 0;
    while (gpio_dir != expected) begin
      @(negedge clk);
      n++;
      if (n > 100) abort_run({"timeout waiting for ", what});
    end
  endtask

  initial begin
    logic [31:0] words [$];
    logic [31:0] w;
    logic [31:0] lost;
    logic [31:0] exp_out;
    logic [31:0] exp_dir;
    logic [31:0] mask3;
    int          n;
    reset   = 1'b1;
    mindex  = '0;
    din     = '0;
    index   = '0;
    action  = act_none;
    gpio_in = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    assert (empty == 4'hf && full == 4'h0)
      else report_error($sformatf("after reset empty %b full %b", empty, full));
    assert (!irq0 && !irq1 && gpio_out == '0 && gpio_dir == '0 && dout == '0)
      else report_error("IRQ lines, pins or dout not zero after reset");

    // Loopback program on machine 1
    load_instr(5'd0, pushpull_word(1'b1, 1'b1));
    load_instr(5'd1, instr_word(op_out, dst_x, 5'd0));
    load_instr(5'd2, instr_word(op_in, dst_x, 5'd0));
    load_instr(5'd3, pushpull_word(1'b0, 1'b1));
    host_action(act_pend, 2'd1, 5'd0, pend_word(0, 3, 0));
    host_action(act_en, 2'd0, 5'd0, 32'b0010);
    for (int k = 0; k < 3; k++) begin
      rand_word(w);
      words.push_back(w);
      host_action(act_push, 2'd1, 5'd0, w);
    end
    for (int k = 0; k < 3; k++) begin
      pull_word(2'd1, w);
      assert (w == words[k])
        else report_error($sformatf("loopback word %0d is %h, expected %h", k, w, words[k]));
    end
    words.delete();

    // Machine 2 fills up while disabled
    host_action(act_pend, 2'd2, 5'd0, pend_word(0, 3, 0));
    for (int k = 0; k < 4; k++) begin
      rand_word(w);
      words.push_back(w);
      host_action(act_push, 2'd2, 5'd0, w);
    end
    assert (full[2]) else report_error("transmit FIFO 2 not full after four pushes");
    rand_word(lost);
    host_action(act_push, 2'd2, 5'd0, lost);             // Dropped
    assert (full[2] && empty[2]) else report_error("FIFO 2 state wrong after fifth push");
    host_action(act_en, 2'd0, 5'd0, 32'b0110);
    n = 0;
    while (full[2]) begin
      @(negedge clk);
      n++;
      if (n > 100) abort_run("timeout waiting for machine 2 to take a word");
    end
    rand_word(w);                                       // Stalls at PUSH behind a full rx
    words.push_back(w);
    host_action(act_push, 2'd2, 5'd0, w);
    // Five loop passes of four steps at div 0 fill rx and leave the machine at PUSH
    repeat (5 * 4 + 4) @(negedge clk);
    for (int k = 0; k < 5; k++) begin
      pull_word(2'd2, w);
      assert (w == words[k])
        else report_error($sformatf("machine 2 word %0d is %h, expected %h", k, w, words[k]));
    end
    words.delete();

    // Machine 3 wins on the overlapping SET groups
    load_instr(5'd4, instr_word(op_set, dst_pins, 5'd3));
    load_instr(5'd5, instr_word(op_set, dst_pindirs, 5'd6));
    load_instr(5'd6, instr_word(op_jmp, cond_always, 5'd6));
    load_instr(5'd8, instr_word(op_set, dst_pins, 5'd2));
    load_instr(5'd9, instr_word(op_set, dst_pindirs, 5'd1));
    load_instr(5'd10, instr_word(op_jmp, cond_always, 5'd10));
    host_action(act_pend, 2'd0, 5'd0, pend_word(4, 6, 6));
    host_action(act_pend, 2'd3, 5'd0, pend_word(8, 10, 10));
    host_action(act_grps, 2'd0, 5'd0, grps_word(8, 3));
    host_action(act_grps, 2'd3, 5'd0, grps_word(9, 2));
    exp_out = place(8, 3, 32'd3);
    exp_dir = place(8, 3, 32'd6);
    host_action(act_en, 2'd0, 5'd0, 32'b0111);
    wait_dirs(exp_dir, "machine 0 pin directions");
    assert (gpio_out == exp_out)
      else report_error($sformatf("gpio_out %h, expected %h", gpio_out, exp_out));
    mask3   = place(9, 2, 32'h3);
    exp_out = (exp_out & ~mask3) | place(9, 2, 32'd2);
    exp_dir = (exp_dir & ~mask3) | place(9, 2, 32'd1);
    host_action(act_en, 2'd0, 5'd0, 32'b1111);
    wait_dirs(exp_dir, "merged pin directions of machines 0 and 3");
    assert (gpio_out == exp_out)
      else report_error($sformatf("merged gpio_out %h, expected %h", gpio_out, exp_out));

    // Counted loop at div 3 ending in IRQ 5
    host_action(act_en, 2'd0, 5'd0, 32'b1110);
    load_instr(5'd12, instr_word(op_set, dst_x, 5'd5));
    load_instr(5'd13, instr_word(op_jmp, cond_xdec, 5'd13));
    load_instr(5'd14, instr_word(op_irq, 3'd0, 5'd5));
    load_instr(5'd15, instr_word(op_jmp, cond_always, 5'd15));
    host_action(act_pend, 2'd0, 5'd0, pend_word(12, 15, 15));
    host_action(act_div, 2'd0, 5'd0, 32'd3);
    host_action(act_en, 2'd0, 5'd0, 32'b1111);
    n = 0;
    while (!irq1) begin
      @(negedge clk);
      n++;
      if (n > 200) abort_run("timeout waiting for irq1");
    end
    assert (n >= 7 * (3 + 1))
      else report_error($sformatf("irq1 rose %0d cycles after enable, too early", n));
    assert (!irq0) else report_error("irq0 set by IRQ 5");
    host_action(act_irqc, 2'd0, 5'd0, 32'h20);
    assert (!irq1 && !irq0) else report_error("IRQ flag 5 not cleared by IRQC");

    if (dut_i.sva_i.error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: test/pio_sva.sv
`timescale 1ns/10ps

module pio_sva import pio_host_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic [1:0]  mindex,
  input logic [3:0]  action,
  input logic [31:0] dout,
  input logic [31:0] gpio_out,
  input logic [31:0] gpio_dir,
  input logic        irq0,
  input logic        irq1,
  input logic [3:0]  full,
  input logic [3:0]  empty
);

  int error_count = 0;

  // Registered outputs settle on the first reset edge
  reset_outputs: assert property (@(posedge clk)
      (reset ##1 reset) |-> (dout == '0) && (gpio_out == '0) && (gpio_dir == '0) &&
                            !irq0 && !irq1 && (full == '0) && (empty == '1))
    else begin
      $error("outputs active while reset is held");
      error_count = error_count + 1;
    end

  dout_hold: assert property (@(posedge clk) disable iff (reset)
      !$past(action == act_pull) |-> $stable(dout))
    else begin
      $error("dout changed without a PULL action");
      error_count = error_count + 1;
    end

  for (genvar j = 0; j < num_machines; j++) begin : tx_full
    full_needs_push: assert property (@(posedge clk) disable iff (reset)
        $rose(full[j]) |-> $past((action == act_push) && (mindex == 2'(j))))
      else begin
        $error("full[%0d] rose without a PUSH to that machine", j);
        error_count = error_count + 1;
      end
  end

endmodule

// File: design/pio.sv
`timescale 1ns/10ps

module pio import pio_host_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic [1:0]  mindex,
  input  logic [31:0] din,
  input  logic [4:0]  index,
  input  logic [3:0]  action,
  output logic [31:0] dout,
  input  logic [31:0] gpio_in,
  output logic [31:0] gpio_out,
  output logic [31:0] gpio_dir,
  output logic        irq0,
  output logic        irq1,
  output logic [3:0]  full,
  output logic [3:0]  empty
);

  logic [15:0]             imem [32];                     // Shared program memory
  logic [num_machines-1:0] en;
  logic [7:0]              irq_flags;
  logic [7:0]              irq_hit;

  logic [4:0]       pstart       [num_machines];
  logic [4:0]       pend         [num_machines];
  logic [4:0]       wrap_target  [num_machines];
  logic [div_w-1:0] div          [num_machines];
  logic [4:0]       out_base     [num_machines];
  logic [4:0]       set_base     [num_machines];
  logic [4:0]       in_base      [num_machines];
  logic [2:0]       out_count    [num_machines];
  logic [2:0]       set_count    [num_machines];
  logic [2:0]       in_count     [num_machines];
  logic [31:0]      initial_pins [num_machines];
  logic [31:0]      initial_dirs [num_machines];

  logic [num_machines-1:0] sel;
  logic [num_machines-1:0] host_push;
  logic [num_machines-1:0] host_pull;
  logic [num_machines-1:0] step;
  logic [num_machines-1:0] tx_pull;
  logic [num_machines-1:0] tx_empty;
  logic [num_machines-1:0] rx_push;
  logic [num_machines-1:0] rx_full;
  logic [num_machines-1:0] irq_set;

  logic [4:0]  pc             [num_machines];
  logic [15:0] m_instr        [num_machines];
  logic [31:0] tx_data        [num_machines];
  logic [31:0] rx_data        [num_machines];
  logic [31:0] rx_head        [num_machines];
  logic [31:0] output_pins    [num_machines];
  logic [31:0] pin_directions [num_machines];
  logic [2:0]  irq_index      [num_machines];

  assign sel       = num_machines'(1) << mindex;
  assign host_push = (action == act_push) ? sel : '0;     // FIFO takes din on this edge
  assign host_pull = (action == act_pull) ? sel : '0;

  always_ff @(posedge clk) begin
    if (action == act_instr) begin
      imem[index] <= din[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en <= '0;
      for (int j = 0; j < num_machines; j++) begin
        pstart[j]       <= '0;
        pend[j]         <= '0;
        wrap_target[j]  <= '0;
        div[j]          <= '0;
        out_base[j]     <= '0;
        set_base[j]     <= '0;
        in_base[j]      <= '0;
        out_count[j]    <= '0;
        set_count[j]    <= '0;
        in_count[j]     <= '0;
        initial_pins[j] <= '0;
        initial_dirs[j] <= '0;
      end
    end else begin
      case (action)
        act_pend: begin
          pend[mindex]        <= din[pend_lsb +: 5];
          pstart[mindex]      <= din[pstart_lsb +: 5];
          wrap_target[mindex] <= din[wrap_lsb +: 5];
        end
        act_grps: begin
          set_count[mindex] <= din[grp_set_count_lsb +: grp_count_w];
          set_base[mindex]  <= din[grp_set_base_lsb +: grp_base_w];
          out_count[mindex] <= din[grp_out_count_lsb +: grp_count_w];
          out_base[mindex]  <= din[grp_out_base_lsb +: grp_base_w];
          in_count[mindex]  <= din[grp_in_count_lsb +: grp_count_w];
          in_base[mindex]   <= din[grp_in_base_lsb +: grp_base_w];
        end
        act_en:    en <= din[num_machines-1:0];
        act_div:   div[mindex] <= din[div_w-1:0];
        act_ipins: initial_pins[mindex] <= din;
        act_idirs: initial_dirs[mindex] <= din;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else if (action == act_pull && !empty[mindex]) begin
      dout <= rx_head[mindex];                            // Pop happens on the same edge
    end
  end

  always_comb begin
    irq_hit = '0;
    for (int j = 0; j < num_machines; j++) begin
      if (irq_set[j]) begin
        irq_hit[irq_index[j]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      irq_flags <= '0;
    end else begin
      irq_flags <= (irq_flags & ~((action == act_irqc) ? din[7:0] : 8'd0)) | irq_hit;
    end
  end

  assign irq0 = |irq_flags[3:0];
  assign irq1 = |irq_flags[7:4];

  // Higher machine index wins where groups overlap
  always_comb begin
    logic [4:0] off_out;
    logic [4:0] off_set;
    gpio_out = '0;
    gpio_dir = '0;
    for (int p = 0; p < 32; p++) begin
      for (int j = 0; j < num_machines; j++) begin
        off_out = 5'(p) - out_base[j];
        off_set = 5'(p) - set_base[j];
        if (en[j] && ((off_out < out_count[j]) || (off_set < set_count[j]))) begin
          gpio_out[p] = output_pins[j][p];
          gpio_dir[p] = pin_directions[j][p];
        end
      end
    end
  end

  for (genvar j = 0; j < num_machines; j++) begin : mach
    assign m_instr[j] = imem[pstart[j] + pc[j]];

    pio_clock_div clock_div_i (
      .clk   (clk),
      .reset (reset),
      .en    (en[j]),
      .div   (div[j]),
      .step  (step[j])
    );

    pio_machine machine_i (
      .clk            (clk),
      .reset          (reset),
      .en             (en[j]),
      .step           (step[j]),
      .instr          (m_instr[j]),
      .pstart         (pstart[j]),
      .pend           (pend[j]),
      .wrap_target    (wrap_target[j]),
      .out_base       (out_base[j]),
      .set_base       (set_base[j]),
      .in_base        (in_base[j]),
      .out_count      (out_count[j]),
      .set_count      (set_count[j]),
      .in_count       (in_count[j]),
      .initial_pins   (initial_pins[j]),
      .initial_dirs   (initial_dirs[j]),
      .gpio_in        (gpio_in),
      .tx_data        (tx_data[j]),
      .tx_empty       (tx_empty[j]),
      .rx_full        (rx_full[j]),
      .pc             (pc[j]),
      .output_pins    (output_pins[j]),
      .pin_directions (pin_directions[j]),
      .tx_pull        (tx_pull[j]),
      .rx_push        (rx_push[j]),
      .rx_data        (rx_data[j]),
      .irq_set        (irq_set[j]),
      .irq_index      (irq_index[j])
    );

    pio_fifo tx_fifo_i (                                  // Host to machine
      .clk   (clk),
      .reset (reset),
      .push  (host_push[j]),
      .pull  (tx_pull[j]),
      .din   (din),
      .dout  (tx_data[j]),
      .full  (full[j]),
      .empty (tx_empty[j])
    );

    pio_fifo rx_fifo_i (                                  // Machine to host
      .clk   (clk),
      .reset (reset),
      .push  (rx_push[j]),
      .pull  (host_pull[j]),
      .din   (rx_data[j]),
      .dout  (rx_head[j]),
      .full  (rx_full[j]),
      .empty (empty[j])
    );
  end

endmodule

// File: design/pio_machine.sv
`timescale 1ns/10ps

module pio_machine import pio_isa_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,
  input  logic        step,
  input  logic [15:0] instr,
  input  logic [4:0]  pstart,
  input  logic [4:0]  pend,
  input  logic [4:0]  wrap_target,
  input  logic [4:0]  out_base,
  input  logic [4:0]  set_base,
  input  logic [4:0]  in_base,
  input  logic [2:0]  out_count,
  input  logic [2:0]  set_count,
  input  logic [2:0]  in_count,
  input  logic [31:0] initial_pins,
  input  logic [31:0] initial_dirs,
  input  logic [31:0] gpio_in,
  input  logic [31:0] tx_data,
  input  logic        tx_empty,
  input  logic        rx_full,
  output logic [4:0]  pc,
  output logic [31:0] output_pins,
  output logic [31:0] pin_directions,
  output logic        tx_pull,
  output logic        rx_push,
  output logic [31:0] rx_data,
  output logic        irq_set,
  output logic [2:0]  irq_index
);

  logic [31:0] x;
  logic [31:0] isr;
  logic [31:0] osr;
  logic [5:0]  isr_cnt;                                   // Bits shifted in
  logic [5:0]  osr_cnt;                                   // Bits shifted out, 32 is empty
  logic [4:0]  delay_cnt;

  logic [2:0]  op;
  logic [2:0]  code;
  logic [4:0]  data;
  logic [5:0]  bit_cnt;
  logic        is_pull;
  logic        is_pp;
  logic        exec;
  logic        stall;
  logic        take_jmp;
  logic [4:0]  next_pc;
  logic [63:0] in_rot;
  logic [31:0] in_word;
  logic [63:0] isr_shift;
  logic [31:0] out_word;

  // Write count pins starting at base, wrapping past pin 31
  function automatic logic [31:0] put_pins(input logic [31:0] pins, input logic [4:0] base,
                                           input logic [2:0] count, input logic [31:0] value);
    logic [31:0] res;
    logic [4:0]  pos;
    res = pins;
    for (int k = 0; k < 8; k++) begin
      pos = base + 5'(k);
      if (k < count) begin
        res[pos] = value[k];
      end
    end
    return res;
  endfunction

  function automatic logic [5:0] sat_add(input logic [5:0] a, input logic [5:0] b);
    logic [6:0] sum;
    sum = a + b;
    return (sum > 7'(shift_full)) ? shift_full : sum[5:0];
  endfunction

  assign op      = instr[op_lsb +: 3];
  assign code    = instr[code_lsb +: 3];
  assign data    = instr[data_lsb +: 5];
  assign is_pull = instr[pull_bit];
  assign is_pp   = (op == op_pushpull);
  assign bit_cnt = (data == 5'd0) ? 6'd32 : {1'b0, data}; // 0 encodes 32

  assign exec  = en && step && (delay_cnt == 5'd0);
  assign stall = is_pp && instr[block_bit] && (is_pull ? tx_empty : rx_full);

  // FIFO strobes fire on the executing edge so the pop lines up with the OSR load
  assign tx_pull   = exec && is_pp && is_pull && !tx_empty;
  assign rx_push   = exec && is_pp && !is_pull && !rx_full;
  assign rx_data   = isr >> (shift_full - isr_cnt);       // Right-justify a partial ISR
  assign irq_set   = exec && (op == op_irq);
  assign irq_index = data[2:0];

  assign in_rot    = {gpio_in, gpio_in} >> in_base;
  assign isr_shift = {in_word, isr} >> bit_cnt;           // New bits enter at the MSB
  assign out_word  = osr & ~(32'hffff_ffff << bit_cnt);

  always_comb begin
    case (code)
      dst_pins: in_word = in_rot[31:0] & ~(32'hffff_ffff << in_count);
      dst_x:    in_word = x;
      default:  in_word = '0;
    endcase
  end

  always_comb begin
    case (code)
      cond_always: take_jmp = 1'b1;
      cond_xzero:  take_jmp = (x == '0);
      cond_xdec:   take_jmp = (x != '0);                  // Tested before the decrement
      cond_osre:   take_jmp = (osr_cnt < shift_full);
      default:     take_jmp = 1'b0;
    endcase
  end

  // pend and wrap_target are absolute, pc is relative to pstart
  assign next_pc = (pstart + pc == pend) ? wrap_target - pstart : pc + 5'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= '0;
      delay_cnt <= '0;
      isr_cnt   <= '0;
      osr_cnt   <= shift_full;
    end else if (!en) begin
      pc             <= '0;
      delay_cnt      <= '0;
      isr_cnt        <= '0;
      osr_cnt        <= shift_full;
      x              <= '0;
      isr            <= '0;
      osr            <= '0;
      output_pins    <= initial_pins;                     // Ready for the enable
      pin_directions <= initial_dirs;
    end else if (step) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 5'd1;
      end else if (!stall) begin
        delay_cnt <= instr[delay_lsb +: 5];
        pc        <= next_pc;
        case (op)
          op_jmp: begin
            if (code == cond_xdec) begin
              x <= x - 32'd1;
            end
            if (take_jmp) begin
              pc <= data - pstart;                        // Jump targets are absolute
            end
          end
          op_in: begin
            isr     <= isr_shift[31:0];
            isr_cnt <= sat_add(isr_cnt, bit_cnt);
          end
          op_out: begin
            osr     <= osr >> bit_cnt;
            osr_cnt <= sat_add(osr_cnt, bit_cnt);
            case (code)
              dst_pins:    output_pins <= put_pins(output_pins, out_base, out_count, out_word);
              dst_x:       x <= out_word;
              dst_pindirs: pin_directions <= put_pins(pin_directions, out_base, out_count,
                                                      out_word);
              default: ;                                  // Null sink
            endcase
          end
          op_pushpull: begin
            if (is_pull) begin
              osr     <= tx_empty ? x : tx_data;          // Non-blocking miss copies x
              osr_cnt <= '0;
            end else begin
              isr     <= '0;                              // Word dropped if rx is full
              isr_cnt <= '0;
            end
          end
          op_set: begin
            case (code)
              dst_pins:    output_pins <= put_pins(output_pins, set_base, set_count, 32'(data));
              dst_x:       x <= 32'(data);
              dst_pindirs: pin_directions <= put_pins(pin_directions, set_base, set_count,
                                                      32'(data));
              default: ;
            endcase
          end
          default: ;                                      // IRQ only pulses irq_set
        endcase
      end
    end
  end

endmodule

// File: design/pio_clock_div.sv
`timescale 1ns/10ps

module pio_clock_div import pio_host_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             en,
  input  logic [div_w-1:0] div,
  output logic             step
);

  logic [div_w-1:0] cnt;

  // Every cycle for div 0, else every div+1 cycles
  assign step = en && (cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else if (!en || step) begin
      cnt <= div;                                         // Preload so first step is div+1 in
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

// File: design/pio_fifo.sv
`timescale 1ns/10ps

module pio_fifo import pio_host_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        push,
  input  logic        pull,
  input  logic [31:0] din,
  output logic [31:0] dout,
  output logic        full,
  output logic        empty
);

  logic [31:0]           mem [fifo_depth];
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic                  do_push;
  logic                  do_pull;

  assign full    = (count == fifo_cnt_w'(fifo_depth));
  assign empty   = (count == '0);
  assign do_push = push && !full;                         // Push on full is dropped
  assign do_pull = pull && !empty;
  assign dout    = mem[rd_ptr];                           // Head word

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pull) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pull) begin
        count <= count + 1'b1;
      end else if (do_pull && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: design/pio_isa_pkg.sv
package pio_isa_pkg;

  // Opcodes in bits 15:13
  localparam logic [2:0] op_jmp      = 3'b000;
  localparam logic [2:0] op_in       = 3'b010;
  localparam logic [2:0] op_out      = 3'b011;
  localparam logic [2:0] op_pushpull = 3'b100;
  localparam logic [2:0] op_irq      = 3'b110;
  localparam logic [2:0] op_set      = 3'b111;

  // Field positions
  localparam int op_lsb    = 13;
  localparam int delay_lsb = 8;                           // 5-bit delay, bits 12:8
  localparam int code_lsb  = 5;                           // Condition or source/destination
  localparam int pull_bit  = 7;                           // 1 pull, 0 push
  localparam int block_bit = 5;
  localparam int data_lsb  = 0;                           // Target, bit count, value, IRQ index

  // Source and destination codes
  localparam logic [2:0] dst_pins    = 3'd0;
  localparam logic [2:0] dst_x       = 3'd1;
  localparam logic [2:0] dst_null    = 3'd3;
  localparam logic [2:0] dst_pindirs = 3'd4;

  // JMP conditions
  localparam logic [2:0] cond_always = 3'd0;
  localparam logic [2:0] cond_xzero  = 3'd1;
  localparam logic [2:0] cond_xdec   = 3'd2;
  localparam logic [2:0] cond_osre   = 3'd7;              // Taken while OSR not empty

  // Shift register counts saturate at a full word
  localparam logic [5:0] shift_full = 6'd32;

endpackage

// File: design/pio_host_pkg.sv
package pio_host_pkg;

  localparam int num_machines = 4;
  localparam int fifo_depth   = 4;                        // Power of two, pointers wrap freely
  localparam int fifo_ptr_w   = $clog2(fifo_depth);
  localparam int fifo_cnt_w   = $clog2(fifo_depth + 1);
  localparam int div_w        = 16;

  // Host action codes
  localparam logic [3:0] act_none  = 4'd0;
  localparam logic [3:0] act_instr = 4'd1;
  localparam logic [3:0] act_pend  = 4'd2;
  localparam logic [3:0] act_pull  = 4'd3;
  localparam logic [3:0] act_push  = 4'd4;
  localparam logic [3:0] act_grps  = 4'd5;
  localparam logic [3:0] act_en    = 4'd6;
  localparam logic [3:0] act_div   = 4'd7;
  localparam logic [3:0] act_irqc  = 4'd9;
  localparam logic [3:0] act_ipins = 4'd12;
  localparam logic [3:0] act_idirs = 4'd13;

  // PEND fields, 5 bits each, absolute addresses
  localparam int pend_lsb   = 0;
  localparam int pstart_lsb = 5;
  localparam int wrap_lsb   = 10;

  // GRPS fields
  localparam int grp_count_w       = 3;
  localparam int grp_base_w        = 5;
  localparam int grp_set_count_lsb = 0;
  localparam int grp_set_base_lsb  = 3;
  localparam int grp_out_count_lsb = 8;
  localparam int grp_out_base_lsb  = 11;
  localparam int grp_in_count_lsb  = 16;
  localparam int grp_in_base_lsb   = 19;

endpackage
